// File: src.f
+incdir+verilog
verilog/switch_pkg.sv
verilog/rd_path_if.sv
verilog/packet_fifo.sv
verilog/in_rd_controller_fsm.sv
verilog/port_cfg_regs.sv
verilog/out_formatter.sv
verilog/switch_in_port.sv
verification/switch_in_port_asserts.sv
verification/switch_in_port_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the switch input port testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f \
    --top-module switch_in_port_tb -o switch_in_port_sim \
    && ./obj_dir/switch_in_port_sim 2>&1 | tee sim.log \
    || echo "build or simulation returned an error"

grep -q "^Simulation finished: PASS$" sim.log \
    && echo "run passed" \
    && exit 0 \
    || { echo "run failed, see sim.log"; exit 1; }

// File: verification/switch_in_port_tb.sv
`timescale 1ns/100ps
`include "switch_settings.svh"

module switch_in_port_tb;

    localparam int MAX_LEN      = `DATA_LENGTH_MAX - 1;
    localparam int TRAFFIC_PKTS = 20;
    // per packet: payload write, grant wait, header and payload read
    localparam int TIMEOUT_CYCLES = (TRAFFIC_PKTS + 2) * (2 * MAX_LEN + 12) + 500;

    logic                   clk;
    logic                   rst_n;
    logic                   wr_en;
    switch_pkg::data_word_t wr_data;
    logic                   full;
    logic                   cfg_we;
    logic [1:0]             cfg_addr;
    switch_pkg::data_word_t cfg_wdata;
    switch_pkg::data_word_t cfg_rdata;
    logic                   start;
    switch_pkg::port_sel_t  rx_in;
    switch_pkg::length_t    data_length;
    logic                   ready_in;
    logic                   ready;
    switch_pkg::port_sel_t  rx_out;
    logic                   pkt_valid;
    switch_pkg::data_word_t pkt_data;
    logic                   pkt_last;

    logic [31:0]            rand_state;
    switch_pkg::data_word_t payload_q [$];   // written, not yet sent
    switch_pkg::data_word_t expect_q [$];
    string                  test_name;
    int                     test_errors;
    int                     tests_passed;
    int                     tests_failed;
    int                     cycle_count;
    int                     src_id;          // model of the source id register
    int                     pkt_sent;

    switch_in_port switch_in_port_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .full        (full),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .start       (start),
        .rx_in       (rx_in),
        .data_length (data_length),
        .ready_in    (ready_in),
        .ready       (ready),
        .rx_out      (rx_out),
        .pkt_valid   (pkt_valid),
        .pkt_data    (pkt_data),
        .pkt_last    (pkt_last)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not end within %0d clock cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int rand_range(int lo, int hi);
        logic [31:0] r;
        r = lcg_next() >> 8;   // low LCG bits are weak
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    task automatic tick();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s, %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic cfg_write(logic [1:0] addr, logic [31:0] data);
        tick();
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        tick();
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read(logic [1:0] addr, output logic [31:0] data);
        cfg_addr = addr;
        #1;                    // read mux is combinational
        data = cfg_rdata;
    endtask

    task automatic set_source();
        logic [31:0] w;
        w = lcg_next();
        cfg_write(switch_pkg::CFG_ADDR_SRC, w);
        src_id = int'(switch_pkg::port_sel_t'(w));
    endtask

    task automatic write_payload(int len);
        switch_pkg::data_word_t w;
        for (int i = 0; i < len; i++) begin
            tick();
            w       = lcg_next();
            wr_en   = 1'b1;
            wr_data = w;
            payload_q.push_back(w);
        end
        tick();
        wr_en = 1'b0;
        // FIFO holds exactly the words not yet sent
        check_value("full", 32'(payload_q.size() >= `FIFO_DEPTH), 32'(full));
    endtask

    // request, grant after a delay, then compare every beat with the model
    task automatic send_packet(int len, int dest, int delay);
        switch_pkg::pkt_word_u hdr;
        hdr               = '0;
        hdr.hdr.marker    = switch_pkg::HDR_MARKER;
        hdr.hdr.src_port  = switch_pkg::port_sel_t'(src_id);
        hdr.hdr.dest_port = switch_pkg::port_sel_t'(dest);
        hdr.hdr.length    = switch_pkg::length_t'(len);
        expect_q.push_back(hdr.raw);
        for (int i = 0; i < len; i++) begin
            expect_q.push_back(payload_q.pop_front());
        end
        tick();
        start       = 1'b1;
        rx_in       = switch_pkg::port_sel_t'(dest);
        data_length = switch_pkg::length_t'(len);
        #1;
        check_value("ready on start", 32'd1, 32'(ready));
        tick();
        start       = 1'b0;
        rx_in       = ~rx_in;         // request fields must come from the latch
        data_length = ~data_length;
        repeat (delay) tick();
        ready_in = 1'b1;
        while (!pkt_valid) tick();
        ready_in = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            check_value("pkt_valid", 32'd1, 32'(pkt_valid));   // no gap inside a packet
            check_value("pkt_data", expect_q.pop_front(), pkt_data);
            check_value("pkt_last", 32'(beat == len), 32'(pkt_last));
            tick();
        end
        check_value("pkt_valid after last", 32'd0, 32'(pkt_valid));
        check_value("rx_out", 32'(dest), 32'(rx_out));
        pkt_sent++;
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [31:0] rd;
        logic [31:0] w;
        int          len;
        int          dest;
        rand_state   = 32'hbbfb_f96f;
        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_data      = '0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        start        = 1'b0;
        rx_in        = '0;
        data_length  = '0;
        ready_in     = 1'b0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        src_id       = 0;
        pkt_sent     = 0;
        repeat (10) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        test_name = "reset_state";
        check_value("ready", 32'd0, 32'(ready));
        check_value("pkt_valid", 32'd0, 32'(pkt_valid));
        check_value("pkt_last", 32'd0, 32'(pkt_last));
        for (int a = 0; a < 3; a++) begin
            cfg_read(2'(a), rd);
            check_value("cfg_rdata", 32'd0, rd);
        end
        finish_test();

        test_name = "register_access";
        repeat (4) begin
            w = lcg_next();
            cfg_write(switch_pkg::CFG_ADDR_CTRL, w);
            cfg_read(switch_pkg::CFG_ADDR_CTRL, rd);
            check_value("ctrl", 32'(w[0]), rd);   // only the enable bit is kept
            set_source();
            cfg_read(switch_pkg::CFG_ADDR_SRC, rd);
            check_value("src", 32'(src_id), rd);
        end
        finish_test();

        test_name = "disabled_port";
        cfg_write(switch_pkg::CFG_ADDR_CTRL, 32'd0);
        len  = rand_range(1, MAX_LEN);
        dest = rand_range(0, `PORT_NUB_TOTAL - 1);
        write_payload(len);
        tick();
        start       = 1'b1;
        rx_in       = switch_pkg::port_sel_t'(dest);
        data_length = switch_pkg::length_t'(len);
        ready_in    = 1'b1;
        #1;
        check_value("ready", 32'd0, 32'(ready));
        repeat (20) begin
            tick();
            start = 1'b0;
            check_value("ready", 32'd0, 32'(ready));
            check_value("pkt_valid", 32'd0, 32'(pkt_valid));
        end
        ready_in = 1'b0;
        finish_test();

        // payload from the dropped request is still in the FIFO
        test_name = "single_packet";
        cfg_write(switch_pkg::CFG_ADDR_CTRL, 32'd1);
        set_source();
        send_packet(len, dest, rand_range(0, 7));
        finish_test();

        test_name = "random_traffic";
        repeat (TRAFFIC_PKTS) begin
            len  = rand_range(1, MAX_LEN);
            dest = rand_range(0, `PORT_NUB_TOTAL - 1);
            set_source();
            write_payload(len);
            send_packet(len, dest, rand_range(0, 7));
        end
        finish_test();

        test_name = "packet_counter";
        tick();
        cfg_read(switch_pkg::CFG_ADDR_COUNT, rd);
        check_value("count", 32'(pkt_sent), rd);
        cfg_write(switch_pkg::CFG_ADDR_COUNT, 32'd0);
        cfg_read(switch_pkg::CFG_ADDR_COUNT, rd);
        check_value("count after clear", 32'd0, rd);
        finish_test();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/switch_in_port_asserts.sv
`timescale 1ns/100ps

// protocol checks on the FIFO and the read controller
module switch_in_port_asserts (
    input logic clk,
    input logic rst_n,
    input logic ready,
    input logic out_sel,
    input logic fifo_rd_en,
    input logic fifo_empty,
    input logic wr_en,
    input logic full
);

    read_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd_en |-> !fifo_empty)
        else $error("FIFO popped while empty");

    // acceptance moves the FSM out of idle, so ready never lasts two cycles
    ready_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> !ready)
        else $error("ready held for more than one cycle");

    // header beat is always followed by payload
    header_then_read: assert property (@(posedge clk) disable iff (!rst_n)
        out_sel |=> fifo_rd_en)
        else $error("no FIFO read in the cycle after the header");

    write_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !full)
        else $error("FIFO written while full");

endmodule

// top level sees both the FIFO flags and the controller commands
bind switch_in_port switch_in_port_asserts switch_in_port_asserts_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (ready),
    .out_sel    (rd_if.out_sel),
    .fifo_rd_en (rd_if.fifo_rd_en),
    .fifo_empty (fifo_empty),
    .wr_en      (wr_en),
    .full       (full)
);

// File: verilog/switch_in_port.sv
`timescale 1ns/100ps

module switch_in_port (
    input  logic                   clk,
    input  logic                   rst_n,
    // payload write side
    input  logic                   wr_en,
    input  switch_pkg::data_word_t wr_data,
    output logic                   full,
    // config bus
    input  logic                   cfg_we,
    input  logic [1:0]             cfg_addr,
    input  switch_pkg::data_word_t cfg_wdata,
    output switch_pkg::data_word_t cfg_rdata,
    // request and grant
    input  logic                   start,
    input  switch_pkg::port_sel_t  rx_in,
    input  switch_pkg::length_t    data_length,
    input  logic                   ready_in,
    output logic                   ready,
    output switch_pkg::port_sel_t  rx_out,
    // packet out
    output logic                   pkt_valid,
    output switch_pkg::data_word_t pkt_data,
    output logic                   pkt_last
);

    rd_path_if rd_if ();

    switch_pkg::data_word_t fifo_rd_data;
    logic                   fifo_empty;    // watched by the bound checks
    logic                   port_enable;
    switch_pkg::port_sel_t  src_port;
    logic                   pkt_done;

    packet_fifo packet_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_if.fifo_rd_en),
        .rd_data (fifo_rd_data),
        .full    (full),
        .empty   (fifo_empty)
    );

    in_rd_controller_fsm in_rd_controller_fsm_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .rx_in       (rx_in),
        .data_length (data_length),
        .ready_in    (ready_in),
        .port_enable (port_enable),
        .ready       (ready),
        .rx_out      (rx_out),
        .pkt_done    (pkt_done),
        .rd          (rd_if.ctrl)
    );

    port_cfg_regs port_cfg_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .pkt_done    (pkt_done),
        .cfg_rdata   (cfg_rdata),
        .port_enable (port_enable),
        .src_port    (src_port)
    );

    out_formatter out_formatter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_data   (fifo_rd_data),
        .src_port  (src_port),
        .pkt_valid (pkt_valid),
        .pkt_data  (pkt_data),
        .pkt_last  (pkt_last),
        .rd        (rd_if.fmt)
    );

endmodule

// File: verilog/out_formatter.sv
`timescale 1ns/100ps

module out_formatter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_pkg::data_word_t rd_data,
    input  switch_pkg::port_sel_t  src_port,
    output logic                   pkt_valid,
    output switch_pkg::data_word_t pkt_data,
    output logic                   pkt_last,
    rd_path_if.fmt                 rd
);

    switch_pkg::pkt_word_u word_n;
    switch_pkg::pkt_word_u word_q;

    // ==================================================
    // header or payload select
    // ==================================================
    always_comb begin
        word_n = '0;
        if (rd.out_sel) begin
            word_n.hdr.marker    = switch_pkg::HDR_MARKER;
            word_n.hdr.src_port  = src_port;
            word_n.hdr.dest_port = rd.rx;
            word_n.hdr.length    = rd.length;
            word_n.hdr.reserved  = '0;
        end else begin
            word_n.raw = rd_data;   // FIFO head, valid this cycle
        end
    end

    // ==================================================
    // output registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
            pkt_last  <= 1'b0;
        end else begin
            pkt_valid <= rd.out_valid;
            pkt_last  <= rd.last;
        end
    end

    // data holds between packets
    always_ff @(posedge clk) begin
        if (rd.out_valid) begin
            word_q <= word_n;
        end
    end

    assign pkt_data = word_q.raw;

endmodule

// File: verilog/port_cfg_regs.sv
`timescale 1ns/100ps

module port_cfg_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  logic [1:0]             cfg_addr,
    input  switch_pkg::data_word_t cfg_wdata,
    input  logic                   pkt_done,
    output switch_pkg::data_word_t cfg_rdata,
    output logic                   port_enable,
    output switch_pkg::port_sel_t  src_port
);

    localparam int CNT_W = 16;

    logic                  enable_reg;
    switch_pkg::port_sel_t src_reg;
    logic [CNT_W-1:0]      pkt_cnt;

    // ==================================================
    // writable registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_reg <= 1'b0;
            src_reg    <= '0;
        end else if (cfg_we) begin
            if (cfg_addr == switch_pkg::CFG_ADDR_CTRL) begin
                enable_reg <= cfg_wdata[0];
            end
            if (cfg_addr == switch_pkg::CFG_ADDR_SRC) begin
                src_reg <= cfg_wdata[switch_pkg::PORT_SEL_W-1:0];
            end
        end
    end

    // packet counter, software clear has priority over a finished packet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt <= '0;
        end else if (cfg_we && (cfg_addr == switch_pkg::CFG_ADDR_COUNT)) begin
            pkt_cnt <= '0;
        end else if (pkt_done) begin
            pkt_cnt <= pkt_cnt + 1'b1;   // wraps
        end
    end

    // read mux
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            switch_pkg::CFG_ADDR_CTRL:  cfg_rdata[0] = enable_reg;
            switch_pkg::CFG_ADDR_SRC:   cfg_rdata[switch_pkg::PORT_SEL_W-1:0] = src_reg;
            switch_pkg::CFG_ADDR_COUNT: cfg_rdata[CNT_W-1:0] = pkt_cnt;
            default:                    cfg_rdata = '0;
        endcase
    end

    assign port_enable = enable_reg;
    assign src_port    = src_reg;

endmodule

// File: verilog/in_rd_controller_fsm.sv
`timescale 1ns/100ps

module in_rd_controller_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  switch_pkg::port_sel_t rx_in,
    input  switch_pkg::length_t   data_length,
    input  logic                  ready_in,
    input  logic                  port_enable,
    output logic                  ready,
    output switch_pkg::port_sel_t rx_out,
    output logic                  pkt_done,
    rd_path_if.ctrl               rd
);

    localparam logic [2:0] IDLE = 3'b000;
    localparam logic [2:0] WAIT = 3'b001;
    localparam logic [2:0] LOAD = 3'b011;
    localparam logic [2:0] RD   = 3'b010;
    localparam logic [2:0] DONE = 3'b111;

    logic [2:0]            state;
    logic [2:0]            state_n;
    switch_pkg::length_t   len_reg;
    switch_pkg::length_t   cnt;
    switch_pkg::port_sel_t rx_reg;
    logic                  accept;
    logic                  cnt_last;

    // request only taken when idle and enabled, otherwise lost
    assign accept   = (state == IDLE) && start && port_enable;
    assign cnt_last = (cnt == len_reg - 1'b1);

    // ==================================================
    // request registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_reg <= '0;
            rx_reg  <= '0;
        end else if (accept) begin
            len_reg <= data_length;
            rx_reg  <= rx_in;
        end
    end

    // payload beat counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (state == DONE) begin
            cnt <= '0;
        end else if (state == RD) begin
            cnt <= cnt + 1'b1;
        end
    end

    // ==================================================
    // state machine
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_n = WAIT;
                end
            end
            WAIT: begin
                if (ready_in) begin      // grant level
                    state_n = LOAD;
                end
            end
            LOAD: state_n = RD;          // header beat
            RD: begin
                if (cnt_last) begin
                    state_n = DONE;
                end
            end
            DONE: state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    // outputs decoded from state
    assign ready         = accept;
    assign pkt_done      = (state == DONE);
    assign rx_out        = rx_reg;

    assign rd.fifo_rd_en = (state == RD);
    assign rd.out_valid  = (state == LOAD) || (state == RD);
    assign rd.out_sel    = (state == LOAD);
    assign rd.last       = (state == RD) && cnt_last;
    assign rd.rx         = rx_reg;
    assign rd.length     = len_reg;

endmodule

// File: verilog/packet_fifo.sv
`timescale 1ns/100ps
`include "switch_settings.svh"

module packet_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  switch_pkg::data_word_t wr_data,
    input  logic                   rd_en,
    output switch_pkg::data_word_t rd_data,
    output logic                   full,
    output logic                   empty
);

    localparam int DEPTH  = `FIFO_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    switch_pkg::data_word_t mem [DEPTH];

    // extra msb on each pointer tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            wr_ok;
    logic            rd_ok;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                   (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

    assign wr_ok = wr_en && !full;   // overflow write dropped
    assign rd_ok = rd_en && !empty;  // underflow read dropped

    // ==================================================
    // storage
    // ==================================================
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    // show-ahead, head word always on the output
    assign rd_data = mem[rd_ptr[ADDR_W-1:0]];

    // ==================================================
    // pointers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: verilog/rd_path_if.sv
`timescale 1ns/100ps

// per-cycle commands from the read controller to the output formatter
interface rd_path_if;

    logic                  fifo_rd_en;  // pop FIFO head this cycle
    logic                  out_valid;
    logic                  out_sel;     // 1 = header beat
    logic                  last;        // final payload beat
    switch_pkg::port_sel_t rx;
    switch_pkg::length_t   length;

    modport ctrl (
        output fifo_rd_en,
        output out_valid,
        output out_sel,
        output last,
        output rx,
        output length
    );

    // fifo_rd_en goes to the FIFO straight from the instance
    modport fmt (
        input  out_valid,
        input  out_sel,
        input  last,
        input  rx,
        input  length
    );

endinterface

// File: verilog/switch_pkg.sv
`include "switch_settings.svh"

package switch_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int PORT_SEL_W = $clog2(`PORT_NUB_TOTAL);
    localparam int LENGTH_W   = $clog2(`DATA_LENGTH_MAX);
    localparam int HDR_RSVD_W = `DATA_WIDTH - 8 - 2 * PORT_SEL_W - LENGTH_W;

    localparam logic [7:0] HDR_MARKER = 8'hA5;   // first byte of every header

    // config register map
    localparam logic [1:0] CFG_ADDR_CTRL  = 2'd0;
    localparam logic [1:0] CFG_ADDR_SRC   = 2'd1;
    localparam logic [1:0] CFG_ADDR_COUNT = 2'd2;

    typedef logic [PORT_SEL_W-1:0]  port_sel_t;
    typedef logic [LENGTH_W-1:0]    length_t;
    typedef logic [`DATA_WIDTH-1:0] data_word_t;

    typedef struct packed {
        logic [7:0]            marker;
        port_sel_t             src_port;
        port_sel_t             dest_port;
        length_t               length;
        logic [HDR_RSVD_W-1:0] reserved;
    } pkt_hdr_t;

    // outgoing word, header beat or raw payload
    typedef union packed {
        pkt_hdr_t   hdr;
        data_word_t raw;
    } pkt_word_u;

endpackage

// File: verilog/switch_settings.svh
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

// payload word width in bits
`define DATA_WIDTH      32

// switch ports, sets the width of a port number
`define PORT_NUB_TOTAL  8

// length field range, legal lengths are 1 .. DATA_LENGTH_MAX-1
`define DATA_LENGTH_MAX 64

// payload FIFO entries
`define FIFO_DEPTH      64

`endif
